// File: bexkat_cpu.f
+incdir+common
common/cpu_pkg.sv
common/regfile_if.sv
common/alu_if.sv
src/cpu_regfile.sv
src/cpu_alu.sv
core/cpu_decode.sv
core/cpu_sequencer.sv
src/bexkat_cpu.sv
tests/bexkat_cpu_assertions.sv
tests/bexkat_cpu_tb.sv

// File: common/alu_if.sv
`include "cpu_config.svh"

interface alu_if;
  logic [`CPU_DATA_W-1:0] in1;
  logic [`CPU_DATA_W-1:0] in2;
  cpu_pkg::alu_func_e     func;
  logic [`CPU_DATA_W-1:0] result;
  cpu_pkg::flags_t        flags;

  modport unit (
    input  in1, in2, func,
    output result, flags
  );
  modport user (
    output in1, in2, func,
    input  result, flags
  );
endinterface

// File: common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// core datapath
`define CPU_DATA_W 32
`define CPU_ADDR_W 32

// memory port, one 16-bit word per access
`define CPU_BUS_W 16
`define CPU_WORD_STEP 32'd2

// register file
`define CPU_REG_AW 5
`define CPU_REG_N 32

`define CPU_RESET_VECTOR 32'hffc0_0000  // monitor base

`endif

// File: common/cpu_pkg.sv
package cpu_pkg;

  typedef enum logic [2:0] {
    mode_inh2  = 3'd0,
    mode_imm3  = 3'd1,
    mode_regind = 3'd2,
    mode_reg   = 3'd3,
    mode_inh   = 3'd4,
    mode_imm2  = 3'd5,
    mode_dir   = 3'd6,
    mode_imm3a = 3'd7
  } mode_e;

  typedef enum logic [3:0] {
    alu_and = 4'd0,
    alu_or  = 4'd1,
    alu_add = 4'd2,
    alu_sub = 4'd3,
    alu_xor = 4'd4,
    alu_lsl = 4'd5,
    alu_lsr = 4'd6
  } alu_func_e;

  typedef enum logic [1:0] {
    reg_none = 2'd0,
    reg_w0   = 2'd1,  // low half
    reg_w1   = 2'd2,  // high half
    reg_dw   = 2'd3
  } reg_write_e;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } flags_t;

  typedef struct packed {
    mode_e      mode;
    logic [2:0] op_hi;
    logic [4:0] rb;
    logic [4:0] ra;
    logic [4:0] op_lo;
    logic [5:0] spare;
    logic [4:0] rc;
  } instr_short_t;

  typedef struct packed {
    mode_e       mode;
    logic [7:0]  opcode;  // overlaps rb
    logic [4:0]  ra;
    logic [15:0] imm;
  } instr_long_t;

  typedef union packed {
    instr_short_t s;
    instr_long_t  l;
  } instr_u;

  typedef enum logic [4:0] {
    op_nop, op_cmp, op_inc, op_dec, op_mov,
    op_alu_reg, op_alu_imm,
    op_ldis, op_ldiu, op_ldi,
    op_branch,
    op_ldd_l, op_std_l, op_ldd, op_std,
    op_jmpd,
    op_need_more,
    op_fault
  } op_e;

endpackage

// File: common/regfile_if.sv
`include "cpu_config.svh"

interface regfile_if;
  logic [`CPU_REG_AW-1:0] read_addr1;
  logic [`CPU_REG_AW-1:0] read_addr2;
  logic [`CPU_REG_AW-1:0] write_addr;
  logic [`CPU_DATA_W-1:0] write_data;
  cpu_pkg::reg_write_e    write_en;
  logic [`CPU_DATA_W-1:0] data1;
  logic [`CPU_DATA_W-1:0] data2;

  modport regs (
    input  read_addr1, read_addr2, write_addr, write_data, write_en,
    output data1, data2
  );
  modport user (
    output read_addr1, read_addr2, write_addr, write_data, write_en,
    input  data1, data2
  );
endinterface

// File: core/cpu_decode.sv
module cpu_decode (
  input  cpu_pkg::instr_u ir,
  input  logic [1:0]      words,
  input  cpu_pkg::flags_t flags,
  output cpu_pkg::op_e    op,
  output logic            branch_taken
);

  logic lt;  // signed less than

  assign lt = flags.negative ^ flags.overflow;

  // condition from the low five opcode bits
  always_comb begin
    case (ir.l.opcode[4:0])
      5'd0:    branch_taken = 1'b1;                   // bra
      5'd1:    branch_taken = flags.zero;
      5'd2:    branch_taken = !flags.zero;
      5'd3:    branch_taken = !(flags.zero || flags.carry);
      5'd4:    branch_taken = !(flags.zero || lt);
      5'd5:    branch_taken = !lt;
      5'd6:    branch_taken = flags.zero || lt;
      5'd7:    branch_taken = lt;
      5'd8:    branch_taken = !flags.carry;
      5'd9:    branch_taken = flags.carry;
      5'd10:   branch_taken = flags.carry || flags.zero;
      default: branch_taken = 1'b0;                   // brn and unused
    endcase
  end

  always_comb begin
    op = cpu_pkg::op_fault;
    if (words == 2'd0) begin
      op = cpu_pkg::op_need_more;
    end else begin
      case (ir.s.mode)
        cpu_pkg::mode_inh: begin
          case (ir.s.op_hi)
            3'd0: op = cpu_pkg::op_nop;
            3'd2: op = cpu_pkg::op_cmp;
            3'd3: op = cpu_pkg::op_inc;
            3'd4: op = cpu_pkg::op_dec;
            3'd7: op = cpu_pkg::op_mov;
            default: op = cpu_pkg::op_fault;
          endcase
        end
        cpu_pkg::mode_reg: begin
          if (words == 2'd1) op = cpu_pkg::op_need_more;
          else if (!ir.s.op_hi[0]) op = cpu_pkg::op_alu_reg;
        end
        cpu_pkg::mode_imm2: begin
          if (words == 2'd1) op = cpu_pkg::op_need_more;
          else if (ir.l.opcode[4])
            op = ir.l.opcode[0] ? cpu_pkg::op_ldiu : cpu_pkg::op_ldis;
          else if (ir.l.opcode[3:0] < 4'd12) op = cpu_pkg::op_branch;
        end
        cpu_pkg::mode_imm3: begin
          if (words != 2'd3) op = cpu_pkg::op_need_more;
          else if (!ir.s.op_hi[0]) op = cpu_pkg::op_alu_imm;
        end
        cpu_pkg::mode_imm3a: begin
          if (words != 2'd3) op = cpu_pkg::op_need_more;
          else if (ir.l.opcode == 8'h00) op = cpu_pkg::op_ldi;
        end
        cpu_pkg::mode_dir: begin
          if (words != 2'd3) op = cpu_pkg::op_need_more;
          else begin
            case (ir.l.opcode)
              8'h00: op = cpu_pkg::op_std_l;
              8'h01: op = cpu_pkg::op_ldd_l;
              8'h02: op = cpu_pkg::op_std;
              8'h03: op = cpu_pkg::op_ldd;
              8'h80: op = cpu_pkg::op_jmpd;
              default: op = cpu_pkg::op_fault;
            endcase
          end
        end
        cpu_pkg::mode_inh2, cpu_pkg::mode_regind: op = cpu_pkg::op_fault;
        default: op = cpu_pkg::op_fault;
      endcase
    end
  end

endmodule

// File: core/cpu_sequencer.sv
`include "cpu_config.svh"

module cpu_sequencer (
  input  logic                   csi_clk,
  input  logic                   rsi_reset_n,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic                   read,
  output logic                   write,
  output logic [1:0]             byteenable,
  output logic [`CPU_BUS_W-1:0]  writedata,
  input  logic [`CPU_BUS_W-1:0]  readdata,
  input  logic                   waitrequest,
  regfile_if.user                rf,
  alu_if.user                    alu,
  output cpu_pkg::instr_u        ir,
  output logic [1:0]             words,
  output cpu_pkg::flags_t        flags,
  input  cpu_pkg::op_e           op,
  input  logic                   branch_taken
);

  localparam logic [2:0] s_fetch  = 3'd0;
  localparam logic [2:0] s_lwait  = 3'd1;
  localparam logic [2:0] s_swait  = 3'd2;
  localparam logic [2:0] s_eval   = 3'd3;
  localparam logic [2:0] s_load2  = 3'd4;
  localparam logic [2:0] s_store2 = 3'd5;
  localparam logic [2:0] s_fault  = 3'd6;
  localparam logic addr_pc  = 1'b0;
  localparam logic addr_mar = 1'b1;
  localparam logic half_hi  = 1'b0;
  localparam logic half_lo  = 1'b1;

  logic [2:0]             state;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] mar;
  logic [`CPU_DATA_W-1:0] mdr;
  logic                   addr_sel;
  logic                   half_sel;   // mdr half on the bus
  logic                   done;
  logic [`CPU_DATA_W-1:0] imm2_sext;  // second word
  logic [`CPU_DATA_W-1:0] imm3_sext;  // third word

  assign address   = (addr_sel == addr_mar) ? mar : pc;
  assign writedata = (half_sel == half_lo) ? mdr[`CPU_BUS_W-1:0]
                                           : mdr[`CPU_DATA_W-1:`CPU_BUS_W];
  assign done      = !waitrequest;  // access ends this edge
  assign imm2_sext = {{`CPU_BUS_W{ir.l.imm[`CPU_BUS_W-1]}}, ir.l.imm};
  assign imm3_sext = {{`CPU_BUS_W{mdr[`CPU_BUS_W-1]}}, mdr[`CPU_BUS_W-1:0]};

  // register file and alu steering
  always_comb begin
    rf.read_addr1 = ir.s.ra;
    rf.read_addr2 = ir.s.rb;
    rf.write_addr = ir.s.ra;
    rf.write_data = alu.result;
    rf.write_en   = cpu_pkg::reg_none;
    alu.in1       = rf.data1;
    alu.in2       = rf.data2;
    alu.func      = cpu_pkg::alu_add;
    case (state)
      s_eval: begin
        case (op)
          cpu_pkg::op_cmp: alu.func = cpu_pkg::alu_sub;
          cpu_pkg::op_inc, cpu_pkg::op_dec: begin
            alu.func    = (op == cpu_pkg::op_dec) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            alu.in2     = `CPU_DATA_W'(1);
            rf.write_en = cpu_pkg::reg_dw;
          end
          cpu_pkg::op_mov: begin
            rf.write_data = rf.data2;
            rf.write_en   = cpu_pkg::reg_dw;
          end
          cpu_pkg::op_alu_reg, cpu_pkg::op_alu_imm: begin
            rf.read_addr1 = ir.s.rb;
            rf.read_addr2 = ir.s.rc;
            alu.func      = cpu_pkg::alu_func_e'(ir.s.op_lo[3:0]);
            if (op == cpu_pkg::op_alu_imm) alu.in2 = imm3_sext;
            rf.write_en   = cpu_pkg::reg_dw;
          end
          cpu_pkg::op_ldis: begin
            rf.write_data = imm2_sext;
            rf.write_en   = cpu_pkg::reg_dw;
          end
          cpu_pkg::op_ldiu: begin
            rf.write_data = {{`CPU_BUS_W{1'b0}}, ir.l.imm};
            rf.write_en   = cpu_pkg::reg_dw;
          end
          cpu_pkg::op_ldi: begin
            rf.write_data = mdr;
            rf.write_en   = cpu_pkg::reg_dw;
          end
          default: ;
        endcase
      end
      s_load2: begin
        rf.write_data = mdr;
        rf.write_en   = cpu_pkg::reg_w1;
      end
      s_lwait: begin
        if (done && addr_sel == addr_mar && half_sel == half_lo) begin
          rf.write_data = {mdr[`CPU_DATA_W-1:`CPU_BUS_W], readdata};
          rf.write_en   = cpu_pkg::reg_w0;  // upper half kept
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state      <= s_fetch;
      pc         <= `CPU_RESET_VECTOR;
      mar        <= '0;
      mdr        <= '0;
      ir         <= '0;
      words      <= '0;
      flags      <= '0;
      addr_sel   <= addr_pc;
      half_sel   <= half_lo;
      read       <= 1'b0;
      write      <= 1'b0;
      byteenable <= 2'b11;
    end else begin
      case (state)
        s_fetch: begin
          read       <= 1'b1;
          byteenable <= 2'b11;
          addr_sel   <= addr_pc;
          state      <= s_lwait;
        end
        s_lwait: begin
          if (done) begin
            read       <= 1'b0;
            byteenable <= 2'b00;
            if (addr_sel == addr_pc) begin
              case (words)
                2'd0: ir <= {readdata, {`CPU_BUS_W{1'b0}}};
                2'd1: ir.l.imm <= readdata;
                default: begin
                  mar <= {ir.l.imm, readdata};  // direct address
                  mdr <= {ir.l.imm, readdata};  // ldi value, imm3 operand
                end
              endcase
              words <= words + 2'd1;
              pc    <= pc + `CPU_WORD_STEP;
              state <= s_eval;
            end else if (half_sel == half_hi) begin
              mdr[`CPU_DATA_W-1:`CPU_BUS_W] <= readdata;
              state <= s_load2;
            end else begin
              state <= s_fetch;
            end
          end
        end
        s_swait: begin
          if (done) begin
            write      <= 1'b0;
            byteenable <= 2'b00;
            state      <= (half_sel == half_hi) ? s_store2 : s_fetch;
          end
        end
        s_load2, s_store2: begin
          read       <= (state == s_load2);
          write      <= (state == s_store2);
          byteenable <= 2'b11;
          mar        <= mar + `CPU_WORD_STEP;
          half_sel   <= half_lo;
          state      <= (state == s_load2) ? s_lwait : s_swait;
        end
        s_eval: begin
          state <= s_fetch;
          if (op != cpu_pkg::op_need_more) words <= '0;
          case (op)
            cpu_pkg::op_cmp:    flags <= alu.flags;
            cpu_pkg::op_branch: if (branch_taken) pc <= pc + imm2_sext;
            cpu_pkg::op_jmpd:   pc <= mar;
            cpu_pkg::op_ldd_l, cpu_pkg::op_ldd: begin
              read       <= 1'b1;
              byteenable <= 2'b11;
              addr_sel   <= addr_mar;
              half_sel   <= (op == cpu_pkg::op_ldd_l) ? half_hi : half_lo;
              state      <= s_lwait;
            end
            cpu_pkg::op_std_l, cpu_pkg::op_std: begin
              write      <= 1'b1;
              byteenable <= 2'b11;
              addr_sel   <= addr_mar;
              mdr        <= rf.data1;
              half_sel   <= (op == cpu_pkg::op_std_l) ? half_hi : half_lo;
              state      <= s_swait;
            end
            cpu_pkg::op_fault:  state <= s_fault;
            default: ;
          endcase
        end
        default: state <= s_fault;  // halted
      endcase
    end
  end

endmodule

// File: src/bexkat_cpu.sv
`include "cpu_config.svh"

module bexkat_cpu (
  input  logic                   csi_clk,
  input  logic                   rsi_reset_n,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic                   read,
  output logic                   write,
  output logic [1:0]             byteenable,
  output logic [`CPU_BUS_W-1:0]  writedata,
  input  logic [`CPU_BUS_W-1:0]  readdata,
  input  logic                   waitrequest
);

  cpu_pkg::instr_u ir;
  logic [1:0]      words;
  cpu_pkg::flags_t flags;
  cpu_pkg::op_e    op;
  logic            branch_taken;

  regfile_if rf_bus ();
  alu_if     alu_bus ();

  cpu_sequencer u_seq (
    .csi_clk, .rsi_reset_n,
    .address, .read, .write, .byteenable, .writedata, .readdata, .waitrequest,
    .rf (rf_bus),
    .alu(alu_bus),
    .ir, .words, .flags, .op, .branch_taken
  );

  cpu_decode u_dec (
    .ir, .words, .flags, .op, .branch_taken
  );

  cpu_alu u_alu (
    .alu(alu_bus)
  );

  cpu_regfile u_regs (
    .csi_clk, .rsi_reset_n,
    .rf(rf_bus)
  );

endmodule

// File: src/cpu_alu.sv
`include "cpu_config.svh"

module cpu_alu (
  alu_if.unit alu
);

  logic [`CPU_DATA_W:0]   sum;   // top bit is carry out
  logic [`CPU_DATA_W:0]   diff;  // top bit is borrow
  logic [`CPU_DATA_W-1:0] res;
  logic                   sign1;
  logic                   sign2;

  assign sum   = {1'b0, alu.in1} + {1'b0, alu.in2};
  assign diff  = {1'b0, alu.in1} - {1'b0, alu.in2};
  assign sign1 = alu.in1[`CPU_DATA_W-1];
  assign sign2 = alu.in2[`CPU_DATA_W-1];

  always_comb begin
    res                = '0;
    alu.flags.carry    = 1'b0;
    alu.flags.overflow = 1'b0;
    case (alu.func)
      cpu_pkg::alu_and: res = alu.in1 & alu.in2;
      cpu_pkg::alu_or:  res = alu.in1 | alu.in2;
      cpu_pkg::alu_add: begin
        res                = sum[`CPU_DATA_W-1:0];
        alu.flags.carry    = sum[`CPU_DATA_W];
        alu.flags.overflow = (sign1 == sign2) && (res[`CPU_DATA_W-1] != sign1);
      end
      cpu_pkg::alu_sub: begin
        res                = diff[`CPU_DATA_W-1:0];
        alu.flags.carry    = diff[`CPU_DATA_W];
        alu.flags.overflow = (sign1 != sign2) && (res[`CPU_DATA_W-1] != sign1);
      end
      cpu_pkg::alu_xor: res = alu.in1 ^ alu.in2;
      cpu_pkg::alu_lsl: res = alu.in1 << alu.in2[4:0];
      cpu_pkg::alu_lsr: res = alu.in1 >> alu.in2[4:0];
      default:          res = '0;  // unused codes
    endcase
    alu.result         = res;
    alu.flags.negative = res[`CPU_DATA_W-1];
    alu.flags.zero     = (res == '0);
  end

endmodule

// File: src/cpu_regfile.sv
`include "cpu_config.svh"

module cpu_regfile (
  input logic     csi_clk,
  input logic     rsi_reset_n,
  regfile_if.regs rf
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (rf.write_en)
        cpu_pkg::reg_w0:
          regs[rf.write_addr][`CPU_BUS_W-1:0] <= rf.write_data[`CPU_BUS_W-1:0];
        cpu_pkg::reg_w1:
          regs[rf.write_addr][`CPU_DATA_W-1:`CPU_BUS_W] <=
            rf.write_data[`CPU_DATA_W-1:`CPU_BUS_W];
        cpu_pkg::reg_dw:
          regs[rf.write_addr] <= rf.write_data;
        default: ;
      endcase
    end
  end

  // read ports are combinational
  assign rf.data1 = regs[rf.read_addr1];
  assign rf.data2 = regs[rf.read_addr2];

endmodule

// File: tests/bexkat_cpu_assertions.sv
`include "cpu_config.svh"

module bexkat_cpu_assertions (
  input logic                   csi_clk,
  input logic                   rsi_reset_n,
  input logic [`CPU_ADDR_W-1:0] address,
  input logic                   read,
  input logic                   write,
  input logic [1:0]             byteenable,
  input logic [`CPU_BUS_W-1:0]  writedata,
  input logic                   waitrequest
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fails = 0;

  one_strobe: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    !(read && write))
    else begin fails++; $error("read and write asserted together"); end

  read_held: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    read && waitrequest |=> read && $stable(address))
    else begin fails++; $error("read dropped or moved under waitrequest"); end

  write_held: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    write && waitrequest |=> write && $stable(address) && $stable(writedata))
    else begin fails++; $error("write dropped or changed under waitrequest"); end

  strobe_drops: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (read || write) && !waitrequest |=> !read && !write && byteenable == 2'b00)
    else begin fails++; $error("strobe still high after completed access"); end

endmodule

bind bexkat_cpu bexkat_cpu_assertions u_assert (.*);

// File: tests/bexkat_cpu_tb.sv
`include "cpu_config.svh"

module bexkat_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period      = 100;
  localparam int word_bound      = 800;  // instruction words of all programs, rounded up
  localparam int worst_access    = 6;    // issue, 3 stretched, done, evaluate
  localparam int fault_window    = 200;
  localparam int watchdog_cycles = word_bound * 3 * worst_access + 6 * 8 + fault_window;

  localparam logic [31:0] vec       = `CPU_RESET_VECTOR;
  localparam logic [31:0] mailbox   = 32'h0000_fff0;
  localparam logic [31:0] data_base = 32'h0000_1000;
  localparam logic [7:0]  std_long  = 8'h00;
  localparam logic [7:0]  ldd_long  = 8'h01;
  localparam logic [7:0]  std_word  = 8'h02;
  localparam logic [7:0]  ldd_word  = 8'h03;
  localparam logic [7:0]  jmp_dir   = 8'h80;

  logic        csi_clk = 1'b0;
  logic        rsi_reset_n;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [1:0]  byteenable;
  logic [15:0] writedata;
  logic [15:0] readdata;
  logic        waitrequest;

  logic [15:0] mem [logic [31:0]];
  logic [15:0] preload [logic [31:0]];
  logic [15:0] prog [$];
  logic [31:0] read_log [$];
  int          write_count;
  logic        mailbox_hit;
  logic [31:0] data_lfsr = 32'hfd2eb642;
  logic [31:0] wait_lfsr = 32'hfd2eb642;
  int          wait_run = 0;
  int          checks = 0;
  int          errors = 0;

  bexkat_cpu DUT (.*);

  always #(clk_period / 2) csi_clk = ~csi_clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_step(data_lfsr);
      r = {r[30:0], data_lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [15:0] stored(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return 16'hxxxx;
  endfunction

  // slave side, waitrequest never high for more than 3 cycles
  always @(posedge csi_clk) begin
    #1;
    wait_lfsr = lfsr_step(wait_lfsr);
    if (wait_run == 3 || !wait_lfsr[0]) begin
      waitrequest = 1'b0;
      wait_run = 0;
    end else begin
      waitrequest = 1'b1;
      wait_run++;
    end
    readdata = mem.exists(address) ? mem[address] : 16'h0000;
  end

  // access completes at the coming edge
  always @(negedge csi_clk) begin
    if (rsi_reset_n && !waitrequest) begin
      if (read) read_log.push_back(address);
      if (write) begin
        mem[address] = writedata;
        write_count++;
        if (address == mailbox) mailbox_hit = 1'b1;
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_long(input string what, input logic [31:0] addr,
                            input logic [31:0] exp);
    check_value(what, {stored(addr), stored(addr + 32'd2)}, exp);
  endtask

  function automatic logic [15:0] head(input logic [2:0] mode, input logic [7:0] opcode,
                                       input logic [4:0] ra);
    return {mode, opcode, ra};
  endfunction

  function automatic logic [31:0] here();
    return vec + 32'(2 * prog.size());
  endfunction

  task automatic inherent(input logic [2:0] op3, input logic [4:0] ra, input logic [4:0] rb);
    prog.push_back(head(3'd4, {op3, rb}, ra));
  endtask

  task automatic alu_reg_op(input logic [3:0] func, input logic [4:0] ra,
                            input logic [4:0] rb, input logic [4:0] rc);
    prog.push_back(head(3'd3, {3'd0, rb}, ra));
    prog.push_back({1'b0, func, 6'd0, rc});
  endtask

  task automatic alu_imm_op(input logic [3:0] func, input logic [4:0] ra,
                            input logic [4:0] rb, input logic [15:0] imm);
    prog.push_back(head(3'd1, {3'd0, rb}, ra));
    prog.push_back({1'b0, func, 11'd0});
    prog.push_back(imm);
  endtask

  task automatic load_short(input logic [4:0] ra, input logic [15:0] imm, input logic zext);
    prog.push_back(head(3'd5, {7'h08, zext}, ra));  // ldis, ldiu
    prog.push_back(imm);
  endtask

  task automatic load_long(input logic [4:0] ra, input logic [31:0] value);
    prog.push_back(head(3'd7, 8'h00, ra));
    prog.push_back(value[31:16]);
    prog.push_back(value[15:0]);
  endtask

  task automatic branch_rel(input logic [3:0] cond, input logic [15:0] offset);
    prog.push_back(head(3'd5, {4'h0, cond}, 5'd0));
    prog.push_back(offset);
  endtask

  task automatic direct_op(input logic [7:0] opcode, input logic [4:0] ra,
                           input logic [31:0] addr);
    prog.push_back(head(3'd6, opcode, ra));
    prog.push_back(addr[31:16]);
    prog.push_back(addr[15:0]);
  endtask

  task automatic new_program();
    prog.delete();
    preload.delete();
  endtask

  task automatic hold_reset();
    @(posedge csi_clk);
    #1;
    rsi_reset_n = 1'b0;
    mem.delete();
    foreach (prog[i]) mem[vec + 32'(2 * i)] = prog[i];
    foreach (preload[a]) mem[a] = preload[a];
    read_log.delete();
    write_count = 0;
    mailbox_hit = 1'b0;
    repeat (5) @(posedge csi_clk);
    #1;
  endtask

  task automatic release_and_wait();
    rsi_reset_n = 1'b1;
    do @(posedge csi_clk); while (!mailbox_hit);
  endtask

  function automatic logic [31:0] alu_model(input int f, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f)
      0: return a & b;
      1: return a | b;
      2: return a + b;
      3: return a - b;
      4: return a ^ b;
      5: return a << b[4:0];
      6: return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic branch_expect(input int c, input logic [31:0] a,
                                         input logic [31:0] b);
    logic slt;
    logic ult;
    slt = $signed(a) < $signed(b);
    ult = a < b;
    case (c)
      0: return 1'b1;
      1: return a == b;
      2: return a != b;
      3: return !ult && a != b;
      4: return !slt && a != b;
      5: return !slt;
      6: return slt || a == b;
      7: return slt;
      8: return !ult;
      9: return ult;
      10: return ult || a == b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_reset_and_fetch();
    int i;
    new_program();
    for (i = 0; i < 4; i++) inherent(3'd0, 5'd0, 5'd0);  // nop
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    check_value("read in reset", read, 1'b0);
    check_value("write in reset", write, 1'b0);
    check_value("byteenable in reset", byteenable, 2'b11);
    check_value("address in reset", address, vec);
    release_and_wait();
    for (i = 0; i < 7; i++) check_value("fetch address", read_log[i], vec + 32'(2 * i));
  endtask

  task automatic load_immediates();
    logic [31:0] v;
    logic [15:0] s;
    logic [15:0] u;
    v = rand_bits(32);
    s = {1'b1, 15'(rand_bits(15))};  // negative, so extension shows
    u = {1'b1, 15'(rand_bits(15))};
    new_program();
    load_long(5'd1, v);
    load_short(5'd2, s, 1'b0);
    load_short(5'd3, u, 1'b1);
    direct_op(std_long, 5'd1, data_base);
    direct_op(std_long, 5'd2, data_base + 32'd4);
    direct_op(std_long, 5'd3, data_base + 32'd8);
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    release_and_wait();
    check_long("ldi", data_base, v);
    check_long("ldis", data_base + 32'd4, {16'hffff, s});
    check_long("ldiu", data_base + 32'd8, {16'h0000, u});
  endtask

  task automatic alu_operations();
    logic [31:0] a [7];
    logic [31:0] b [7];
    logic [15:0] imm [7];
    logic [31:0] c;
    int f;
    new_program();
    for (f = 0; f < 7; f++) begin
      a[f] = rand_bits(32);
      b[f] = rand_bits(32);
      imm[f] = 16'(rand_bits(16));
      load_long(5'd1, a[f]);
      load_long(5'd2, b[f]);
      alu_reg_op(4'(f), 5'd3, 5'd1, 5'd2);
      direct_op(std_long, 5'd3, data_base + 32'(4 * f));
      alu_imm_op(4'(f), 5'd4, 5'd1, imm[f]);
      direct_op(std_long, 5'd4, data_base + 32'h100 + 32'(4 * f));
    end
    c = rand_bits(32);
    load_long(5'd5, c);
    inherent(3'd3, 5'd5, 5'd0);  // inc
    direct_op(std_long, 5'd5, data_base + 32'h200);
    load_long(5'd6, c);
    inherent(3'd4, 5'd6, 5'd0);  // dec
    direct_op(std_long, 5'd6, data_base + 32'h204);
    inherent(3'd7, 5'd7, 5'd1);  // mov r7, r1
    direct_op(std_long, 5'd7, data_base + 32'h208);
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    release_and_wait();
    for (f = 0; f < 7; f++) begin
      check_long($sformatf("alu reg func %0d", f), data_base + 32'(4 * f),
                 alu_model(f, a[f], b[f]));
      check_long($sformatf("alu imm func %0d", f), data_base + 32'h100 + 32'(4 * f),
                 alu_model(f, a[f], {{16{imm[f][15]}}, imm[f]}));
    end
    check_long("inc", data_base + 32'h200, c + 32'd1);
    check_long("dec", data_base + 32'h204, c - 32'd1);
    check_long("mov", data_base + 32'h208, a[6]);
  endtask

  task automatic compare_and_branch();
    logic [31:0] pa [4];
    logic [31:0] pb [4];
    logic [31:0] slot;
    int p;
    int c;
    pa = '{32'h0000_0005, 32'h0000_0003, 32'hffff_fff0, 32'h7fff_ffff};
    pb = '{32'h0000_0005, 32'h0000_0007, 32'h0000_0010, 32'h8000_0000};
    new_program();
    load_short(5'd10, 16'h1111, 1'b1);  // not taken marker
    load_short(5'd11, 16'h2222, 1'b1);  // taken marker
    for (p = 0; p < 4; p++) begin
      load_long(5'd1, pa[p]);
      load_long(5'd2, pb[p]);
      inherent(3'd2, 5'd1, 5'd2);  // cmp r1, r2
      for (c = 0; c < 12; c++) begin
        slot = data_base + 32'(2 * (p * 12 + c));
        branch_rel(4'(c), 16'd10);
        direct_op(std_word, 5'd10, slot);
        branch_rel(4'd0, 16'd6);
        direct_op(std_word, 5'd11, slot);
      end
    end
    slot = data_base + 32'h400;
    direct_op(jmp_dir, 5'd0, here() + 32'd12);  // past the next store
    direct_op(std_word, 5'd10, slot);
    direct_op(std_word, 5'd11, slot);
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    release_and_wait();
    for (p = 0; p < 4; p++) begin
      for (c = 0; c < 12; c++) begin
        check_value($sformatf("branch %0d pair %0d", c, p),
                    stored(data_base + 32'(2 * (p * 12 + c))),
                    branch_expect(c, pa[p], pb[p]) ? 16'h2222 : 16'h1111);
      end
    end
    check_value("jmpd target", stored(slot), 16'h2222);
  endtask

  task automatic memory_round_trip();
    logic [31:0] w;
    logic [31:0] v;
    logic [15:0] h;
    w = rand_bits(32);
    v = rand_bits(32);
    h = 16'(rand_bits(16));
    new_program();
    preload[data_base] = w[31:16];
    preload[data_base + 32'd2] = w[15:0];
    preload[data_base + 32'd4] = h;
    direct_op(ldd_long, 5'd1, data_base);
    direct_op(std_long, 5'd1, data_base + 32'd8);
    load_long(5'd2, v);
    direct_op(ldd_word, 5'd2, data_base + 32'd4);  // low half only
    direct_op(std_long, 5'd2, data_base + 32'd12);
    direct_op(std_word, 5'd1, data_base + 32'd16);
    direct_op(ldd_long, 5'd3, data_base + 32'd8);
    direct_op(std_long, 5'd3, data_base + 32'd20);
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    release_and_wait();
    check_long("ldd.l then std.l", data_base + 32'd8, w);
    check_long("ldd keeps upper half", data_base + 32'd12, {v[31:16], h});
    check_value("std low half", stored(data_base + 32'd16), w[15:0]);
    check_long("stored words read back", data_base + 32'd20, w);
    check_value("mailbox word", stored(mailbox), 16'h0000);
  endtask

  task automatic undecoded_halt();
    new_program();
    inherent(3'd0, 5'd0, 5'd0);
    inherent(3'd1, 5'd0, 5'd0);  // no such inherent op
    direct_op(std_word, 5'd0, mailbox);
    hold_reset();
    rsi_reset_n = 1'b1;
    repeat (fault_window) @(posedge csi_clk);
    check_value("reads before halt", read_log.size(), 2);
    check_value("writes after fault", write_count, 0);
    check_value("read low in fault", read, 1'b0);
    check_value("write low in fault", write, 1'b0);
  endtask

  initial begin
    int total;
    rsi_reset_n = 1'b0;
    readdata = '0;
    waitrequest = 1'b0;
    check_reset_and_fetch();
    load_immediates();
    alu_operations();
    compare_and_branch();
    memory_round_trip();
    undecoded_halt();
    total = errors + int'(DUT.u_assert.fails);
    $display("%0d checks, %0d mismatches, %0d assertion failures",
             checks, errors, DUT.u_assert.fails);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
